/* hdl/emesh_pkg.sv */
/*
 * emesh packet definitions
 * field widths of the mesh link and the packed 104-bit packet layout
 * shared by the translator, the config port and the testbench
 */
`default_nettype none

package emesh_pkg;

   localparam int mesh_aw  = 32;   // address word
   localparam int mesh_dw  = 32;   // data word
   localparam int emesh_pw = 104;  // full packet width

   // ctrl takes whatever is left of the packet after the three words
   localparam int mesh_ctrl_w = emesh_pw - 2*mesh_aw - mesh_dw;

   typedef logic [mesh_aw-1:0]     mesh_addr_t;
   typedef logic [mesh_dw-1:0]     mesh_data_t;
   typedef logic [mesh_ctrl_w-1:0] mesh_ctrl_t;

   // msb first, matches the wire layout of the link
   typedef struct packed {
      mesh_addr_t srcaddr;  // 103:72
      mesh_data_t data;     // 71:40
      mesh_addr_t dstaddr;  // 39:8, the translated field
      mesh_ctrl_t ctrl;     // 7:0
   } emesh_packet_t;

endpackage

`default_nettype wire

/* hdl/mmu_pkg.sv */
/*
 * mmu table and config definitions
 * translation table geometry, entry and index types, write lane masks
 * and the field layout of the config port address
 */
`default_nettype none

package mmu_pkg;

   localparam int mmu_entry_w = 48;
   localparam int mmu_index_w = 12;
   localparam int mmu_entries = 1 << mmu_index_w;  // 4096 entries
   localparam int mmu_lanes_w = mmu_entry_w / 8;   // one enable per byte
   localparam int mmu_page_w  = 20;                // offset kept from dstaddr
   localparam int mi_group_w  = 4;

   typedef logic [mmu_entry_w-1:0] mmu_entry_t;
   typedef logic [mmu_index_w-1:0] mmu_index_t;
   typedef logic [mmu_lanes_w-1:0] mmu_lanes_t;

   localparam logic [mi_group_w-1:0] mmu_group = '0;  // our config group

   // low half is bytes 0-3, upper half bytes 4-5
   localparam mmu_lanes_t mmu_lanes_lo = 6'b00_1111;
   localparam mmu_lanes_t mmu_lanes_hi = 6'b11_0000;

   // 20-bit config address
   typedef struct packed {
      logic [mi_group_w-1:0] group;  // 19:16
      logic                  rsvd_hi;  // 15
      mmu_index_t            index;  // 14:3
      logic                  half;   // 2, set selects entry bits 47:32
      logic [1:0]            rsvd_lo;  // word aligned
   } mi_addr_t;

endpackage

`default_nettype wire

/* hdl/mmu_table.sv */
/*
 * translation table
 * 4096 x 48 storage, byte lane writes from the config side,
 * a registered lookup port for the translator and a registered
 * readback port for the config side
 */
`timescale 1ns/100ps
`default_nettype none

module mmu_table import mmu_pkg::*; (
   input  wire        clk,
   // config writes
   input  mmu_lanes_t wr_lanes,
   input  mmu_index_t wr_index,
   input  mmu_entry_t wr_data,
   // translator lookup
   input  wire        lookup_en,
   input  mmu_index_t lookup_index,
   output mmu_entry_t lookup_entry,
   // config readback
   input  wire        cfg_rd_en,
   input  mmu_index_t cfg_rd_index,
   output mmu_entry_t cfg_rd_entry
);

   mmu_entry_t mem [mmu_entries];

   // byte wide write, lanes picked by the decoder
   always_ff @(posedge clk) begin
      for (int i = 0; i < mmu_lanes_w; i++) begin
         if (wr_lanes[i]) begin
            mem[wr_index][i*8 +: 8] <= wr_data[i*8 +: 8];
         end
      end
   end

   // lookup read, holds while the translator is stalled
   always_ff @(posedge clk) begin
      if (lookup_en) begin
         lookup_entry <= mem[lookup_index];
      end
   end

   // readback port, independent of the lookup
   always_ff @(posedge clk) begin
      if (cfg_rd_en) begin
         cfg_rd_entry <= mem[cfg_rd_index];  // old data on same-cycle write
      end
   end

endmodule

`default_nettype wire

/* hdl/mmu_cfg.sv */
/*
 * config port decoder
 * matches the group field, turns the half bit into byte lane enables,
 * spreads mi_din over the entry and returns the selected half of a
 * readback one cycle after the read
 */
`timescale 1ns/100ps
`default_nettype none

module mmu_cfg import emesh_pkg::*, mmu_pkg::*; (
   input  wire        clk,
   input  wire        reset,
   // config port
   input  wire        mi_en,
   input  wire        mi_we,
   input  mi_addr_t   mi_addr,
   input  mesh_data_t mi_din,
   output mesh_data_t mi_dout,
   // table write side
   output mmu_lanes_t wr_lanes,
   output mmu_index_t wr_index,
   output mmu_entry_t wr_data,
   // table readback side
   output logic       cfg_rd_en,
   output mmu_index_t cfg_rd_index,
   input  mmu_entry_t cfg_rd_entry
);

   logic       match;      // access aimed at this unit
   logic       rd_valid;   // table readback lands this cycle
   logic       rd_half;    // half bit of that read
   mesh_data_t rd_word;    // selected half, zero extended
   mesh_data_t dout_hold;  // last returned word

   assign match = mi_en & (mi_addr.group == mmu_group);

   // write decode
   always_comb begin
      wr_lanes = '0;
      if (match && mi_we) begin
         wr_lanes = mi_addr.half ? mmu_lanes_hi : mmu_lanes_lo;
      end
   end

   assign wr_index = mi_addr.index;
   // upper lanes take the low 16 bits of the word
   assign wr_data  = {mi_din[mmu_entry_w-mesh_dw-1:0], mi_din};

   // readback request goes straight to the table
   assign cfg_rd_en    = match & ~mi_we;
   assign cfg_rd_index = mi_addr.index;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_valid <= 1'b0;
         rd_half  <= 1'b0;
      end else begin
         rd_valid <= cfg_rd_en;
         if (cfg_rd_en) begin
            rd_half <= mi_addr.half;  // needed when the entry returns
         end
      end
   end

   // half select on the registered table output
   always_comb begin
      if (rd_half) begin
         rd_word = mesh_data_t'(cfg_rd_entry[mmu_entry_w-1:mesh_dw]);  // bits 47:32
      end else begin
         rd_word = cfg_rd_entry[mesh_dw-1:0];
      end
   end

   // keep the word around once the read cycle is over
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         dout_hold <= '0;
      end else if (rd_valid) begin
         dout_hold <= rd_word;
      end
   end

   assign mi_dout = rd_valid ? rd_word : dout_hold;  // no extra cycle of latency

endmodule

`default_nettype wire

/* hdl/emmu.sv */
/*
 * emesh address translator
 * indexes the table with dstaddr bits 31:20, stages the packet for
 * the one cycle lookup and rebuilds it with the translated address.
 * the high address word goes out on the side port. a single stage,
 * held as a whole while the downstream wait is high
 */
`timescale 1ns/100ps
`default_nettype none

module emmu import emesh_pkg::*, mmu_pkg::*; (
   input  wire           clk,
   input  wire           reset,
   // controls
   input  wire           mmu_en,     // static enable
   input  wire           mmu_bp,     // per packet bypass
   // mesh input
   input  wire           emesh_access_in,
   input  emesh_packet_t emesh_packet_in,
   input  wire           emesh_wait_in,
   // table lookup
   output logic          lookup_en,
   output mmu_index_t    lookup_index,
   input  mmu_entry_t    lookup_entry,
   // mesh output
   output logic          emesh_access_out,
   output emesh_packet_t emesh_packet_out,
   output mesh_addr_t    emesh_packet_hi_out
);

   // packet and its bypass flag travel together through the stage
   typedef struct packed {
      emesh_packet_t packet;
      logic          bypass;
   } stage_t;

   stage_t stage_q;

   logic                   translate;  // use the table entry
   logic [2*mesh_aw-1:0]   xlat_addr;  // full 64-bit translated address
   mesh_addr_t             dst_lo;     // dstaddr written back to the packet

   // accept only when downstream is not waiting
   assign lookup_en    = emesh_access_in & ~emesh_wait_in;
   assign lookup_index = emesh_packet_in.dstaddr[mmu_page_w +: mmu_index_w];

   // valid flag, frozen by wait
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         emesh_access_out <= 1'b0;
      end else if (!emesh_wait_in) begin
         emesh_access_out <= emesh_access_in;
      end
   end

   // payload staging, loads with the table read
   always_ff @(posedge clk) begin
      if (lookup_en) begin
         stage_q.packet <= emesh_packet_in;
         stage_q.bypass <= mmu_bp;  // sampled with its own packet
      end
   end

   assign translate = mmu_en & ~stage_q.bypass;

   // entry 43:0 on top of the page offset
   assign xlat_addr = {lookup_entry[2*mesh_aw-mmu_page_w-1:0],
                       stage_q.packet.dstaddr[mmu_page_w-1:0]};

   assign dst_lo = translate ? xlat_addr[mesh_aw-1:0] : stage_q.packet.dstaddr;

   // rebuild the packet, only dstaddr can change
   always_comb begin
      emesh_packet_out         = stage_q.packet;
      emesh_packet_out.dstaddr = dst_lo;
   end

   // high word, zero when not translating
   assign emesh_packet_hi_out = translate ? xlat_addr[2*mesh_aw-1:mesh_aw] : '0;

endmodule

`default_nettype wire

/* hdl/emmu_top.sv */
/*
 * emmu subsystem
 * config decoder, translation table and translator on one clock
 */
`timescale 1ns/100ps
`default_nettype none

module emmu_top import emesh_pkg::*, mmu_pkg::*; (
   input  wire           clk,
   input  wire           reset,
   // config port
   input  wire           mi_en,
   input  wire           mi_we,
   input  mi_addr_t      mi_addr,
   input  mesh_data_t    mi_din,
   output mesh_data_t    mi_dout,
   // mesh input
   input  wire           emesh_access_in,
   input  emesh_packet_t emesh_packet_in,
   input  wire           emesh_wait_in,  // shared with the sender
   // controls
   input  wire           mmu_en,
   input  wire           mmu_bp,
   // mesh output
   output logic          emesh_access_out,
   output emesh_packet_t emesh_packet_out,
   output mesh_addr_t    emesh_packet_hi_out
);

   mmu_lanes_t wr_lanes;
   mmu_index_t wr_index;
   mmu_entry_t wr_data;
   logic       cfg_rd_en;
   mmu_index_t cfg_rd_index;
   mmu_entry_t cfg_rd_entry;
   logic       lookup_en;
   mmu_index_t lookup_index;
   mmu_entry_t lookup_entry;

   mmu_cfg u_cfg (
      .clk          (clk),
      .reset        (reset),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .mi_dout      (mi_dout),
      .wr_lanes     (wr_lanes),
      .wr_index     (wr_index),
      .wr_data      (wr_data),
      .cfg_rd_en    (cfg_rd_en),
      .cfg_rd_index (cfg_rd_index),
      .cfg_rd_entry (cfg_rd_entry)
   );

   mmu_table u_table (
      .clk          (clk),
      .wr_lanes     (wr_lanes),
      .wr_index     (wr_index),
      .wr_data      (wr_data),
      .lookup_en    (lookup_en),
      .lookup_index (lookup_index),
      .lookup_entry (lookup_entry),
      .cfg_rd_en    (cfg_rd_en),
      .cfg_rd_index (cfg_rd_index),
      .cfg_rd_entry (cfg_rd_entry)
   );

   emmu u_emmu (
      .clk                 (clk),
      .reset               (reset),
      .mmu_en              (mmu_en),
      .mmu_bp              (mmu_bp),
      .emesh_access_in     (emesh_access_in),
      .emesh_packet_in     (emesh_packet_in),
      .emesh_wait_in       (emesh_wait_in),
      .lookup_en           (lookup_en),
      .lookup_index        (lookup_index),
      .lookup_entry        (lookup_entry),
      .emesh_access_out    (emesh_access_out),
      .emesh_packet_out    (emesh_packet_out),
      .emesh_packet_hi_out (emesh_packet_hi_out)
   );

endmodule

`default_nettype wire

/* dv/emmu_sva.sv */
/*
 * emmu assertions
 * reset value of the valid flag, output hold under wait and the
 * zero side port whenever the table is not used
 */
`timescale 1ns/100ps
`default_nettype none

module emmu_sva import emesh_pkg::*; (
   input wire           clk,
   input wire           reset,
   input wire           mmu_en,
   input wire           emesh_wait_in,
   input wire           stage_bypass,   // staged bypass flag of the packet out
   input wire           emesh_access_out,
   input emesh_packet_t emesh_packet_out,
   input mesh_addr_t    emesh_packet_hi_out
);

   property access_low_in_reset;
      @(posedge clk) reset |-> !emesh_access_out;
   endproperty

   // whole output stage frozen for the edge after a wait
   property hold_on_wait;
      @(posedge clk) disable iff (reset)
         emesh_wait_in |=> $stable(emesh_access_out) && $stable(emesh_packet_out)
                           && $stable(emesh_packet_hi_out);
   endproperty

   property hi_zero_untranslated;
      @(posedge clk) disable iff (reset)
         (!mmu_en || stage_bypass) |-> (emesh_packet_hi_out == '0);
   endproperty

   a_access_low: assert property (access_low_in_reset)
      else $error("emesh_access_out high in reset");
   a_hold_wait: assert property (hold_on_wait)
      else $error("emmu outputs moved while emesh_wait_in was high");
   a_hi_zero: assert property (hi_zero_untranslated)
      else $error("emesh_packet_hi_out not zero with translation off");

endmodule

bind emmu emmu_sva u_sva (
   .clk                 (clk),
   .reset               (reset),
   .mmu_en              (mmu_en),
   .emesh_wait_in       (emesh_wait_in),
   .stage_bypass        (stage_q.bypass),
   .emesh_access_out    (emesh_access_out),
   .emesh_packet_out    (emesh_packet_out),
   .emesh_packet_hi_out (emesh_packet_hi_out)
);

`default_nettype wire

/* dv/emmu_tb.sv */
/*
 * emmu testbench
 * config writes and readback, translated, bypassed and stalled packets,
 * all from one stimulus table and checked against a model of the table
 */
`timescale 1ns/100ps
`default_nettype none

module emmu_tb import emesh_pkg::*, mmu_pkg::*; ();

   typedef enum logic [1:0] {op_write, op_read, op_packet} op_t;

   typedef struct packed {
      op_t         kind;
      logic [31:0] addr;    // mi_addr for config rows, dstaddr for packets
      logic [31:0] data;    // mi_din, unused by packets
      logic        bypass;
      logic        en;      // mmu_en while the packet is in flight
      logic [3:0]  stall;   // wait cycles with the packet held at the input
   } row_t;

   // expected output of one accepted packet
   typedef struct packed {
      emesh_packet_t pkt;
      mesh_addr_t    hi;
   } exp_t;

   typedef logic [emesh_pw-1:0] cval_t;  // widest compared value

   logic          clk;
   logic          reset;
   logic          mi_en;
   logic          mi_we;
   mi_addr_t      mi_addr;
   mesh_data_t    mi_din;
   mesh_data_t    mi_dout;
   logic          emesh_access_in;
   emesh_packet_t emesh_packet_in;
   logic          emesh_wait_in;
   logic          mmu_en;
   logic          mmu_bp;
   logic          emesh_access_out;
   emesh_packet_t emesh_packet_out;
   mesh_addr_t    emesh_packet_hi_out;

   row_t          rows[$];
   exp_t          exp_q[$];               // accepted, not yet at the output
   mmu_entry_t    ref_tab [mmu_index_t];  // table model
   logic [31:0]   lfsr_q;
   int            check_cnt;
   int            err_cnt;
   logic          held;                   // wait high at the last edge
   logic          last_access;
   emesh_packet_t last_pkt;
   mesh_addr_t    last_hi;

   emmu_top dut (
      .clk                 (clk),
      .reset               (reset),
      .mi_en               (mi_en),
      .mi_we               (mi_we),
      .mi_addr             (mi_addr),
      .mi_din              (mi_din),
      .mi_dout             (mi_dout),
      .emesh_access_in     (emesh_access_in),
      .emesh_packet_in     (emesh_packet_in),
      .emesh_wait_in       (emesh_wait_in),
      .mmu_en              (mmu_en),
      .mmu_bp              (mmu_bp),
      .emesh_access_out    (emesh_access_out),
      .emesh_packet_out    (emesh_packet_out),
      .emesh_packet_hi_out (emesh_packet_hi_out)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns period
   end

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         v = {v[30:0], lfsr_q[0]};  // one step per bit
      end
   endtask

   task automatic check(input string name, input cval_t got, input cval_t exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("FAILED %s: got %0h expected %0h", name, got, exp);
      end
   endtask

   task automatic note_error(input string msg);
      err_cnt++;
      $display("ERROR: %s", msg);
   endtask

   // config write into the model, only for our group
   function automatic void model_write(mi_addr_t a, mesh_data_t d);
      mmu_entry_t ent;
      if (a.group == mmu_group) begin
         ent = ref_tab.exists(a.index) ? ref_tab[a.index] : 'x;
         if (a.half) begin
            ent[47:32] = d[15:0];  // upper half, top 16 bits of d dropped
         end else begin
            ent[31:0] = d;
         end
         ref_tab[a.index] = ent;
      end
   endfunction

   function automatic mesh_data_t model_read(mi_addr_t a);
      mmu_entry_t ent;
      ent = ref_tab.exists(a.index) ? ref_tab[a.index] : 'x;
      return a.half ? {16'h0, ent[47:32]} : ent[31:0];
   endfunction

   // translated address is {entry 43:0, page offset 19:0}
   function automatic exp_t expect_packet(emesh_packet_t p, logic bp, logic en);
      exp_t        e;
      mmu_entry_t  ent;
      logic [63:0] full;
      ent  = ref_tab.exists(p.dstaddr[31:20]) ? ref_tab[p.dstaddr[31:20]] : 'x;
      full = {ent[43:0], p.dstaddr[19:0]};
      e.pkt = p;
      e.hi  = '0;
      if (en && !bp) begin
         e.pkt.dstaddr = full[31:0];
         e.hi          = full[63:32];
      end
      return e;
   endfunction

   // output side, runs on the falling edge before new inputs go out
   task automatic watch_outputs();
      exp_t e;
      if (held) begin
         check("emesh_access_out", cval_t'(emesh_access_out), cval_t'(last_access));
         check("emesh_packet_out", cval_t'(emesh_packet_out), cval_t'(last_pkt));
         check("emesh_packet_hi_out", cval_t'(emesh_packet_hi_out), cval_t'(last_hi));
      end else if (emesh_access_out) begin
         if (exp_q.size() == 0) begin
            note_error("emesh_access_out went high with no packet accepted");
         end else begin
            e = exp_q.pop_front();
            check("emesh_packet_out", cval_t'(emesh_packet_out), cval_t'(e.pkt));
            check("emesh_packet_hi_out", cval_t'(emesh_packet_hi_out), cval_t'(e.hi));
         end
      end else if (exp_q.size() != 0) begin
         note_error("accepted packet did not reach the output after one cycle");
         void'(exp_q.pop_front());
      end
      last_access = emesh_access_out;
      last_pkt    = emesh_packet_out;
      last_hi     = emesh_packet_hi_out;
   endtask

   // one clock, acceptance noted at the rising edge
   task automatic step();
      @(posedge clk);
      held = emesh_wait_in;
      if (emesh_access_in && !emesh_wait_in) begin
         exp_q.push_back(expect_packet(emesh_packet_in, mmu_bp, mmu_en));
      end
      @(negedge clk);
      watch_outputs();
   endtask

   task automatic drain();
      int guard;
      emesh_access_in = 1'b0;
      mmu_bp          = 1'b0;
      guard           = 0;
      while (exp_q.size() != 0 && guard < 16) begin
         step();
         guard++;
      end
      if (exp_q.size() != 0) begin
         note_error("timed out waiting for emesh_access_out");
         exp_q.delete();
      end
   endtask

   task automatic apply_row(input row_t r);
      mesh_data_t    rd_exp;
      emesh_packet_t pkt;
      logic [31:0]   bits;
      case (r.kind)
         op_write: begin
            drain();
            mi_en   = 1'b1;
            mi_we   = 1'b1;
            mi_addr = mi_addr_t'(r.addr[19:0]);
            mi_din  = r.data;
            model_write(mi_addr_t'(r.addr[19:0]), r.data);
            step();
            mi_en = 1'b0;
            mi_we = 1'b0;
         end
         op_read: begin
            drain();
            mi_en   = 1'b1;
            mi_we   = 1'b0;
            mi_addr = mi_addr_t'(r.addr[19:0]);
            rd_exp  = model_read(mi_addr_t'(r.addr[19:0]));
            step();
            check("mi_dout", cval_t'(mi_dout), cval_t'(rd_exp));
            mi_en = 1'b0;
            step();
            check("mi_dout", cval_t'(mi_dout), cval_t'(rd_exp));  // held, no new read
         end
         default: begin
            if (r.en != mmu_en) begin
               drain();
               mmu_en = r.en;
               step();  // outputs settle on the new enable
            end
            take_bits(32, bits);
            pkt.srcaddr = bits;
            take_bits(32, bits);
            pkt.data = bits;
            take_bits(8, bits);
            pkt.ctrl    = bits[7:0];
            pkt.dstaddr = r.addr;
            emesh_packet_in = pkt;
            mmu_bp          = r.bypass;
            emesh_access_in = 1'b1;
            if (r.stall != 4'd0) begin
               emesh_wait_in = 1'b1;  // previous packet sits in the output stage
               repeat (r.stall) step();
               emesh_wait_in = 1'b0;
            end
            step();
         end
      endcase
   endtask

   task automatic add_cfg(input op_t k, input logic [3:0] grp, input mmu_index_t idx,
                          input logic half, input mesh_data_t d);
      mi_addr_t a;
      row_t     r;
      a       = '0;
      a.group = grp;
      a.index = idx;
      a.half  = half;
      r       = '0;
      r.kind  = k;
      r.addr  = {12'h0, a};
      r.data  = d;
      rows.push_back(r);
   endtask

   task automatic add_pkt(input mesh_addr_t dst, input logic bp, input logic en,
                          input logic [3:0] st);
      row_t r;
      r        = '0;
      r.kind   = op_packet;
      r.addr   = dst;
      r.bypass = bp;
      r.en     = en;
      r.stall  = st;
      rows.push_back(r);
   endtask

   task automatic build_table();
      // both halves of five entries, corners included
      add_cfg(op_write, 4'h0, 12'h000, 1'b0, 32'h1111_2222);
      add_cfg(op_write, 4'h0, 12'h000, 1'b1, 32'hdead_a5a5);
      add_cfg(op_write, 4'h0, 12'hfff, 1'b0, 32'h89ab_cdef);
      add_cfg(op_write, 4'h0, 12'hfff, 1'b1, 32'h0000_7f01);
      add_cfg(op_write, 4'h0, 12'h005, 1'b0, 32'h0f0f_1234);
      add_cfg(op_write, 4'h0, 12'h005, 1'b1, 32'hffff_8001);
      add_cfg(op_write, 4'h0, 12'h123, 1'b0, 32'hcafe_f00d);
      add_cfg(op_write, 4'h0, 12'h123, 1'b1, 32'h0000_0042);
      add_cfg(op_write, 4'h0, 12'habc, 1'b0, 32'h5555_aaaa);
      add_cfg(op_write, 4'h0, 12'habc, 1'b1, 32'h1234_0777);
      add_cfg(op_read,  4'h0, 12'h000, 1'b0, 32'h0);
      add_cfg(op_read,  4'h0, 12'h000, 1'b1, 32'h0);
      add_cfg(op_read,  4'h0, 12'hfff, 1'b0, 32'h0);
      add_cfg(op_read,  4'h0, 12'hfff, 1'b1, 32'h0);
      add_cfg(op_read,  4'h0, 12'h005, 1'b1, 32'h0);
      add_cfg(op_read,  4'h0, 12'h123, 1'b1, 32'h0);
      add_cfg(op_read,  4'h0, 12'habc, 1'b0, 32'h0);
      // other groups, must not land
      add_cfg(op_write, 4'h3, 12'h005, 1'b0, 32'hbad0_bad0);
      add_cfg(op_write, 4'h1, 12'h005, 1'b1, 32'h0000_beef);
      add_cfg(op_write, 4'hf, 12'h000, 1'b0, 32'hffff_ffff);
      add_cfg(op_read,  4'h0, 12'h005, 1'b0, 32'h0);
      add_cfg(op_read,  4'h0, 12'h005, 1'b1, 32'h0);
      add_cfg(op_read,  4'h0, 12'h000, 1'b0, 32'h0);
      // back to back, bypass alternating
      add_pkt({12'h005, 20'h12345}, 1'b0, 1'b1, 4'd0);
      add_pkt({12'h123, 20'habcde}, 1'b1, 1'b1, 4'd0);
      add_pkt({12'h000, 20'h00001}, 1'b0, 1'b1, 4'd0);
      add_pkt({12'hfff, 20'hfffff}, 1'b1, 1'b1, 4'd0);
      add_pkt({12'habc, 20'h5a5a5}, 1'b0, 1'b1, 4'd0);
      // stalls with one packet out and the next held
      add_pkt({12'h123, 20'h00f00}, 1'b0, 1'b1, 4'd0);
      add_pkt({12'hfff, 20'h80000}, 1'b0, 1'b1, 4'd5);
      add_pkt({12'h000, 20'h7ffff}, 1'b1, 1'b1, 4'd3);
      add_pkt({12'h005, 20'h00000}, 1'b0, 1'b1, 4'd2);
      // unit disabled
      add_pkt({12'h005, 20'h13579}, 1'b0, 1'b0, 4'd0);
      add_pkt({12'habc, 20'h24680}, 1'b0, 1'b0, 4'd0);
      add_pkt({12'habc, 20'h0c0c0}, 1'b0, 1'b1, 4'd1);
   endtask

   initial begin
      reset           = 1'b1;
      mi_en           = 1'b0;
      mi_we           = 1'b0;
      mi_addr         = '0;
      mi_din          = '0;
      emesh_access_in = 1'b0;
      emesh_packet_in = '0;
      emesh_wait_in   = 1'b0;
      mmu_en          = 1'b1;
      mmu_bp          = 1'b0;
      lfsr_q          = 32'h7b4;
      check_cnt       = 0;
      err_cnt         = 0;
      held            = 1'b0;
      build_table();
      repeat (16) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      check("emesh_access_out", cval_t'(emesh_access_out), '0);
      check("mi_dout", cval_t'(mi_dout), '0);
      last_access = emesh_access_out;
      last_pkt    = emesh_packet_out;
      last_hi     = emesh_packet_hi_out;
      foreach (rows[i]) begin
         apply_row(rows[i]);
      end
      drain();
      $display("emmu_tb: %0d checks, %0d errors", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb.f */
hdl/emesh_pkg.sv
hdl/mmu_pkg.sv
hdl/mmu_table.sv
hdl/mmu_cfg.sv
hdl/emmu.sv
hdl/emmu_top.sv
dv/emmu_sva.sv
dv/emmu_tb.sv

/* Makefile */
# Verilator flow for the emmu testbench
TOP := emmu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

# pass only if the run prints the pass line
sim:
	verilator --binary -j 0 --assert --top-module $(TOP) -f tb.f -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
